// ==== verilog.f ====
+incdir+src
src/mipsPkg.sv
src/controlUnit.sv
src/branchJudge.sv
src/registerFile.sv
src/cp0Registers.sv
src/decodeStage.sv
sim/decodeStageProperties.sv
sim/decodeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f verilog.f \
    --top-module decodeStageTb \
    -o decodeStageTb

./obj_dir/decodeStageTb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sim/decodeStim.txt ====
# kind(0 write,1 decode,2 exception) instr pcPlus4 fwdA fwdB fwdMem fwdWb regWrite writeReg writeData
# cp0Write cp0Addr excValid excCode excPc excDs stall | aluOp ctrl rs rt pcTarget redir ds status epc cause
0 0 400004 0 0 0 0 1 1 5 0 0 0 0 0 0 0 6 2100 0 0 400004 0 0 2 0 0
0 0 400008 0 0 0 0 1 2 fffffff0 0 0 0 0 0 0 0 6 2100 0 0 400008 0 0 2 0 0
0 0 40000c 0 0 0 0 1 3 1000 0 0 0 0 0 0 0 6 2100 0 0 40000c 0 0 2 0 0
1 222021 400010 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2100 5 fffffff0 400010 0 0 2 0 0
0 0 400014 0 0 0 0 1 0 deadbeef 0 0 0 0 0 0 0 6 2100 0 0 400014 0 0 2 0 0
1 32823 400018 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2100 0 1000 400018 0 0 2 0 0
1 223024 40001c 2 3 11111111 22222222 0 0 0 0 0 0 0 0 0 0 2 2100 11111111 11111111 40001c 0 0 2 0 0
1 223825 400020 1 0 11111111 22222222 0 0 0 0 0 0 0 0 0 0 3 2100 22222222 fffffff0 400020 0 0 2 0 0
1 2428fffc 400024 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2280 5 0 400024 0 0 2 0 0
1 8c690008 400028 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3680 1000 0 400028 0 0 2 0 0
1 ac620004 40002c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a80 1000 fffffff0 40002c 0 0 2 0 0
1 3c0a1234 400030 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 2200 0 0 400030 0 0 2 0 0
1 fc000000 400034 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 1 0 0 400034 0 0 2 0 0
1 10210004 400100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 c0 5 5 400110 1 0 2 0 0
1 14210004 400104 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 c0 5 5 400104 0 1 2 0 0
1 440fffe 400200 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 1c0 fffffff0 0 4001f8 1 1 2 0 0
1 0 400204 0 0 0 0 0 0 0 0 0 0 0 0 0 1 6 2100 0 0 400204 0 1 2 0 0
1 4310001 400300 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 21c0 5 0 400304 1 1 2 0 0
1 c100040 400308 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 2120 0 0 400100 1 1 2 0 0
1 600008 40030c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 110 1000 0 1000 1 1 2 0 0
1 40826000 400310 0 0 0 0 0 0 ff01 1 c 0 0 0 0 0 9 2 0 fffffff0 400310 0 1 2 0 0
0 0 400314 0 0 0 0 0 0 400500 1 e 0 0 0 0 0 6 2100 0 0 400314 0 0 ff01 0 0
2 0 400318 0 0 0 0 0 0 0 0 0 1 a 400604 1 0 6 2100 0 0 400318 0 0 ff01 400500 0
1 42000018 40031c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 8 0 0 400600 1 0 ff03 400600 80000028
1 400b6800 400320 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9 2004 0 0 400320 0 0 ff03 400600 80000028

// ==== sim/decodeStageTb.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module decodeStageTb import mipsPkg::*; ();

    localparam int MAX_VEC = 64;
    localparam int FIELDS = 27;

    logic clk;
    logic rst;
    logic [`DATA_W-1:0] instr, pcPlus4, fwdMem, fwdWb, writeData, excPc;
    logic [1:0] forwardA, forwardB;
    logic regWrite, cp0Write, excValid, excInDelaySlot, stall;
    logic [`REG_ADDR_W-1:0] writeReg, cp0Addr;
    logic [4:0] excCode;
    aluOpT aluOp;
    logic regWriteD, memReadD, memWriteD, memToRegD, aluSrcB, regDst, immSigned;
    logic isBranch, isJump, isJumpReg, eretD, mfc0D, mtc0D, reservedInstr;
    logic [`DATA_W-1:0] rsValue, rtValue, pcPlus8, pcTarget, statusData, causeData, epc;
    logic [`REG_ADDR_W-1:0] rsAddr, rtAddr, rdAddr;
    logic [15:0] imm16;
    logic pcRedirect, branchTaken, isDelaySlot;

    logic [31:0] vectors [MAX_VEC][FIELDS];
    int vecCount = 0;
    int curVec = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    decodeStage decodeStage_inst (.*);

    bind decodeStage decodeStageProperties decodeStageProperties_inst (
        .clk(clk), .rst(rst), .reservedInstr(reservedInstr), .regWriteD(regWriteD),
        .memWriteD(memWriteD), .branchTaken(branchTaken), .isBranch(isBranch),
        .isDelaySlot(isDelaySlot)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("Timeout: the vectors did not finish within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: vector %0d %s got %h expected %h",
                     $time, curVec, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic loadVectors();
        int fd;
        int got;
        string line;
        logic [31:0] f [FIELDS];
        fd = $fopen("sim/decodeStim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/decodeStim.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            // skip comments and blank lines
            if (got == 0 || line.len() < 2 || line[0] == "#") continue;
            got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                f[22], f[23], f[24], f[25], f[26]);
            if (got != FIELDS || vecCount >= MAX_VEC) begin
                $display("Malformed or excess stimulus line: %s", line);
                $display("TEST RESULT: FAIL");
                $fatal(1, "bad stimulus file");
            end
            for (int i = 0; i < FIELDS; i++) begin
                vectors[vecCount][i] = f[i];
            end
            vecCount++;
        end
        $fclose(fd);
    endtask

    task automatic applyVector(input int n);
        instr <= vectors[n][1];
        pcPlus4 <= vectors[n][2];
        forwardA <= vectors[n][3][1:0];
        forwardB <= vectors[n][4][1:0];
        fwdMem <= vectors[n][5];
        fwdWb <= vectors[n][6];
        regWrite <= vectors[n][7][0];
        writeReg <= vectors[n][8][4:0];
        writeData <= vectors[n][9];
        cp0Write <= vectors[n][10][0];
        cp0Addr <= vectors[n][11][4:0];
        excValid <= vectors[n][12][0];
        excCode <= vectors[n][13][4:0];
        excPc <= vectors[n][14];
        excInDelaySlot <= vectors[n][15][0];
        stall <= vectors[n][16][0];
    endtask

    task automatic compareOutputs(input int n);
        logic [31:0] ctrl;
        logic [31:0] expInstr;
        logic [4:0] expRd;
        logic expTaken;
        ctrl = {18'd0, regWriteD, memReadD, memWriteD, memToRegD, aluSrcB, regDst, immSigned,
                isBranch, isJump, isJumpReg, eretD, mfc0D, mtc0D, reservedInstr};
        expInstr = vectors[n][1];
        // and-link branches and jumps name r31
        if (vectors[n][18][13] && (vectors[n][18][6] || vectors[n][18][5])) begin
            expRd = 5'd31;
        end else begin
            expRd = expInstr[15:11];
        end
        // only a conditional branch reports taken
        expTaken = vectors[n][22][0] & vectors[n][18][6];
        checkValue({28'd0, aluOp}, vectors[n][17], "aluOp");
        checkValue(ctrl, vectors[n][18], "control word");
        checkValue(rsValue, vectors[n][19], "rsValue");
        checkValue(rtValue, vectors[n][20], "rtValue");
        checkValue(pcTarget, vectors[n][21], "pcTarget");
        checkValue({31'd0, pcRedirect}, vectors[n][22], "pcRedirect");
        checkValue({31'd0, isDelaySlot}, vectors[n][23], "isDelaySlot");
        checkValue(statusData, vectors[n][24], "Status");
        checkValue(epc, vectors[n][25], "EPC");
        checkValue(causeData, vectors[n][26], "Cause");
        checkValue({27'd0, rsAddr}, {27'd0, expInstr[25:21]}, "rsAddr");
        checkValue({27'd0, rtAddr}, {27'd0, expInstr[20:16]}, "rtAddr");
        checkValue({27'd0, rdAddr}, {27'd0, expRd}, "rdAddr");
        checkValue({16'd0, imm16}, {16'd0, expInstr[15:0]}, "imm16");
        checkValue({31'd0, branchTaken}, {31'd0, expTaken}, "branchTaken");
        // link value is always the address after the delay slot
        checkValue(pcPlus8, pcPlus4 + 32'd4, "pcPlus8");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instr = '0;
        pcPlus4 = '0;
        forwardA = '0;
        forwardB = '0;
        fwdMem = '0;
        fwdWb = '0;
        regWrite = 1'b0;
        writeReg = '0;
        writeData = '0;
        cp0Write = 1'b0;
        cp0Addr = '0;
        excValid = 1'b0;
        excCode = '0;
        excPc = '0;
        excInDelaySlot = 1'b0;
        stall = 1'b0;
        loadVectors();
        cycleLimit = vecCount * 4 + 100;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < vecCount; n++) begin
            @(posedge clk);
            applyVector(n);
            curVec = n + 1;
            @(negedge clk);
            compareOutputs(n);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim/decodeStageProperties.sv ====
`timescale 1ns/1ps

module decodeStageProperties (
    input logic clk,
    input logic rst,
    input logic reservedInstr,
    input logic regWriteD,
    input logic memWriteD,
    input logic branchTaken,
    input logic isBranch,
    input logic isDelaySlot
);

    // unknown encodings must not write anything
    reservedNoWrite: assert property (@(posedge clk) disable iff (rst)
        reservedInstr |-> !(regWriteD || memWriteD))
        else $error("reservedInstr raised together with a write enable");

    takenNeedsBranch: assert property (@(posedge clk) disable iff (rst)
        branchTaken |-> isBranch)
        else $error("branchTaken high without isBranch");

    // flag cleared by reset
    slotClearAfterReset: assert property (@(posedge clk)
        $past(rst) |-> !isDelaySlot)
        else $error("isDelaySlot high in the cycle after reset");

endmodule

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module decodeStage import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DATA_W-1:0]     instr,
    input  logic [`DATA_W-1:0]     pcPlus4,
    input  logic [1:0]             forwardA,
    input  logic [1:0]             forwardB,
    input  logic [`DATA_W-1:0]     fwdMem,
    input  logic [`DATA_W-1:0]     fwdWb,
    input  logic                   regWrite,
    input  logic [`REG_ADDR_W-1:0] writeReg,
    input  logic [`DATA_W-1:0]     writeData,
    input  logic                   cp0Write,
    input  logic [`REG_ADDR_W-1:0] cp0Addr,
    input  logic                   excValid,
    input  logic [4:0]             excCode,
    input  logic [`DATA_W-1:0]     excPc,
    input  logic                   excInDelaySlot,
    input  logic                   stall,
    output aluOpT                  aluOp,
    output logic                   regWriteD,
    output logic                   memReadD,
    output logic                   memWriteD,
    output logic                   memToRegD,
    output logic                   aluSrcB,
    output logic                   regDst,
    output logic                   immSigned,
    output logic                   isBranch,
    output logic                   isJump,
    output logic                   isJumpReg,
    output logic                   eretD,
    output logic                   mfc0D,
    output logic                   mtc0D,
    output logic                   reservedInstr,
    output logic [`DATA_W-1:0]     rsValue,
    output logic [`DATA_W-1:0]     rtValue,
    output logic [`REG_ADDR_W-1:0] rsAddr,
    output logic [`REG_ADDR_W-1:0] rtAddr,
    output logic [`REG_ADDR_W-1:0] rdAddr,
    output logic [15:0]            imm16,
    output logic [`DATA_W-1:0]     pcPlus8,
    output logic [`DATA_W-1:0]     pcTarget,
    output logic                   pcRedirect,
    output logic                   branchTaken,
    output logic                   isDelaySlot,
    output logic [`DATA_W-1:0]     statusData,
    output logic [`DATA_W-1:0]     causeData,
    output logic [`DATA_W-1:0]     epc
);

    logic linkWrite;

    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign imm16 = instr[15:0];
    // jal and the REGIMM links go to r31, jalr keeps rd
    assign rdAddr = (linkWrite && !isJumpReg) ? 5'd31 : instr[15:11];

    controlUnit controlUnit_inst (
        .clk(clk), .rst(rst), .stall(stall), .instr(instr), .linkWrite(linkWrite),
        .aluOp(aluOp), .regWriteD(regWriteD), .memReadD(memReadD),
        .memWriteD(memWriteD), .memToRegD(memToRegD), .aluSrcB(aluSrcB),
        .regDst(regDst), .immSigned(immSigned), .isBranch(isBranch),
        .isJump(isJump), .isJumpReg(isJumpReg), .eretD(eretD), .mfc0D(mfc0D),
        .mtc0D(mtc0D), .reservedInstr(reservedInstr), .isDelaySlot(isDelaySlot)
    );

    branchJudge branchJudge_inst (
        .instr(instr), .pcPlus4(pcPlus4), .rsValue(rsValue), .rtValue(rtValue),
        .isBranch(isBranch), .isJump(isJump), .isJumpReg(isJumpReg),
        .eretD(eretD), .epc(epc), .branchTaken(branchTaken),
        .linkWrite(linkWrite), .pcRedirect(pcRedirect), .pcTarget(pcTarget),
        .pcPlus8(pcPlus8)
    );

    registerFile registerFile_inst (
        .clk(clk), .rst(rst), .regWrite(regWrite), .writeReg(writeReg),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .writeData(writeData),
        .fwdMem(fwdMem), .fwdWb(fwdWb), .forwardA(forwardA),
        .forwardB(forwardB), .rsValue(rsValue), .rtValue(rtValue)
    );

    cp0Registers cp0Registers_inst (
        .clk(clk), .rst(rst), .cp0Write(cp0Write), .excValid(excValid),
        .excInDelaySlot(excInDelaySlot), .cp0Addr(cp0Addr),
        .writeData(writeData), .excPc(excPc), .excCode(excCode),
        .statusData(statusData), .causeData(causeData), .epc(epc)
    );

endmodule

// ==== src/cp0Registers.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module cp0Registers (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cp0Write,
    input  logic                   excValid,
    input  logic                   excInDelaySlot,
    input  logic [`REG_ADDR_W-1:0] cp0Addr,
    input  logic [`DATA_W-1:0]     writeData,
    input  logic [`DATA_W-1:0]     excPc,
    input  logic [4:0]             excCode,
    output logic [`DATA_W-1:0]     statusData,
    output logic [`DATA_W-1:0]     causeData,
    output logic [`DATA_W-1:0]     epc
);

    // status: IM[15:8], EXL[1], IE[0]
    localparam logic [`DATA_W-1:0] STATUS_MASK = 32'h0000_FF03;
    localparam logic [`DATA_W-1:0] STATUS_BOOT = 32'h0000_0002;
    // cause: software interrupt pending bits only
    localparam logic [`DATA_W-1:0] CAUSE_MASK = 32'h0000_0300;
    localparam int EXL_BIT = 1;
    localparam int BD_BIT = 31;

    logic [`DATA_W-1:0] status;
    logic [`DATA_W-1:0] cause;
    logic [`DATA_W-1:0] epcReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= STATUS_BOOT;
            cause <= '0;
            epcReg <= '0;
        end else if (excValid) begin
            // restart at the branch when the fault is in its slot
            epcReg <= excInDelaySlot ? excPc - `DATA_W'd4 : excPc;
            cause[BD_BIT] <= excInDelaySlot;
            cause[6:2] <= excCode;
            status[EXL_BIT] <= 1'b1;
        end else if (cp0Write) begin
            case (cp0Addr)
                `CP0_STATUS: status <= (status & ~STATUS_MASK) | (writeData & STATUS_MASK);
                `CP0_CAUSE: cause <= (cause & ~CAUSE_MASK) | (writeData & CAUSE_MASK);
                `CP0_EPC: epcReg <= writeData;
                default: ;
            endcase
        end
    end

    assign statusData = status;
    assign causeData = cause;
    assign epc = epcReg;

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   regWrite,
    input  logic [`REG_ADDR_W-1:0] writeReg,
    input  logic [`REG_ADDR_W-1:0] rsAddr,
    input  logic [`REG_ADDR_W-1:0] rtAddr,
    input  logic [`DATA_W-1:0]     writeData,
    input  logic [`DATA_W-1:0]     fwdMem,
    input  logic [`DATA_W-1:0]     fwdWb,
    input  logic [1:0]             forwardA,
    input  logic [1:0]             forwardB,
    output logic [`DATA_W-1:0]     rsValue,
    output logic [`DATA_W-1:0]     rtValue
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];
    logic [`DATA_W-1:0] rsRead;
    logic [`DATA_W-1:0] rtRead;

    // MEM bypass wins over WB bypass
    function automatic logic [`DATA_W-1:0] fwdSel(
        input logic [1:0]         sel,
        input logic [`DATA_W-1:0] memVal,
        input logic [`DATA_W-1:0] wbVal,
        input logic [`DATA_W-1:0] fileVal
    );
        if (sel[1]) begin
            return memVal;
        end else if (sel[0]) begin
            return wbVal;
        end
        return fileVal;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && writeReg != '0) begin
            regs[writeReg] <= writeData;
        end
    end

    // r0 is hardwired
    assign rsRead = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtRead = (rtAddr == '0) ? '0 : regs[rtAddr];

    assign rsValue = fwdSel(forwardA, fwdMem, fwdWb, rsRead);
    assign rtValue = fwdSel(forwardB, fwdMem, fwdWb, rtRead);

endmodule

// ==== src/branchJudge.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module branchJudge import mipsPkg::*; (
    input  logic [`DATA_W-1:0] instr,
    input  logic [`DATA_W-1:0] pcPlus4,
    input  logic [`DATA_W-1:0] rsValue,
    input  logic [`DATA_W-1:0] rtValue,
    input  logic               isBranch,
    input  logic               isJump,
    input  logic               isJumpReg,
    input  logic               eretD,
    input  logic [`DATA_W-1:0] epc,
    output logic               branchTaken,
    output logic               linkWrite,
    output logic               pcRedirect,
    output logic [`DATA_W-1:0] pcTarget,
    output logic [`DATA_W-1:0] pcPlus8
);

    opcodeT opcode;
    regimmT rtCode;
    logic condMet;
    logic rsNeg;
    logic [`DATA_W-1:0] branchAddr;
    logic [`DATA_W-1:0] jumpAddr;

    assign opcode = opcodeT'(instr[31:26]);
    assign rtCode = regimmT'(instr[20:16]);
    assign rsNeg = rsValue[`DATA_W-1];

    always_comb begin
        condMet = 1'b0;
        case (opcode)
            OP_BEQ: condMet = (rsValue == rtValue);
            OP_BNE: condMet = (rsValue != rtValue);
            OP_REGIMM: begin
                case (rtCode)
                    RI_BLTZ, RI_BLTZAL: condMet = rsNeg;
                    RI_BGEZ, RI_BGEZAL: condMet = ~rsNeg;
                    default: condMet = 1'b0;
                endcase
            end
            default: condMet = 1'b0;
        endcase
    end

    assign branchTaken = isBranch & condMet;

    // and-link forms write r31 (rd for jalr) whether taken or not
    assign linkWrite = (isJump && opcode == OP_JAL)
                     || (isJumpReg && functT'(instr[5:0]) == FN_JALR)
                     || (isBranch && opcode == OP_REGIMM
                         && (rtCode == RI_BLTZAL || rtCode == RI_BGEZAL));

    assign branchAddr = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jumpAddr = {pcPlus4[31:28], instr[25:0], 2'b00};
    assign pcPlus8 = pcPlus4 + `DATA_W'd4;

    assign pcRedirect = eretD | isJumpReg | isJump | branchTaken;

    always_comb begin
        if (eretD) begin
            pcTarget = epc;
        end else if (isJumpReg) begin
            pcTarget = rsValue;
        end else if (isJump) begin
            pcTarget = jumpAddr;
        end else if (branchTaken) begin
            pcTarget = branchAddr;
        end else begin
            pcTarget = pcPlus4;
        end
    end

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module controlUnit import mipsPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic [`DATA_W-1:0]  instr,
    input  logic                linkWrite,
    output aluOpT               aluOp,
    output logic                regWriteD,
    output logic                memReadD,
    output logic                memWriteD,
    output logic                memToRegD,
    output logic                aluSrcB,
    output logic                regDst,
    output logic                immSigned,
    output logic                isBranch,
    output logic                isJump,
    output logic                isJumpReg,
    output logic                eretD,
    output logic                mfc0D,
    output logic                mtc0D,
    output logic                reservedInstr,
    output logic                isDelaySlot
);

    // COP0 rs field and the eret function code
    localparam logic [4:0] COP_MF = 5'h00;
    localparam logic [4:0] COP_MT = 5'h04;
    localparam logic [4:0] COP_CO = 5'h10;
    localparam logic [5:0] COP_ERET = 6'h18;

    logic regWriteDec;

    always_comb begin
        aluOp = ALU_PASS;
        regWriteDec = 1'b0;
        memReadD = 1'b0;
        memWriteD = 1'b0;
        memToRegD = 1'b0;
        aluSrcB = 1'b0;
        regDst = 1'b0;
        immSigned = 1'b0;
        isBranch = 1'b0;
        isJump = 1'b0;
        isJumpReg = 1'b0;
        eretD = 1'b0;
        mfc0D = 1'b0;
        mtc0D = 1'b0;
        reservedInstr = 1'b0;
        case (opcodeT'(instr[31:26]))
            OP_SPECIAL: begin
                regDst = 1'b1;
                regWriteDec = 1'b1;
                case (functT'(instr[5:0]))
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    // jalr link write comes from the branch unit
                    FN_JR, FN_JALR: begin
                        regWriteDec = 1'b0;
                        isJumpReg = 1'b1;
                    end
                    default: reservedInstr = 1'b1;
                endcase
            end
            OP_REGIMM: begin
                regDst = 1'b1;
                immSigned = 1'b1;
                case (regimmT'(instr[20:16]))
                    RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL: isBranch = 1'b1;
                    default: reservedInstr = 1'b1;
                endcase
            end
            OP_BEQ, OP_BNE: begin
                aluOp = ALU_SUB;
                immSigned = 1'b1;
                isBranch = 1'b1;
            end
            OP_J: isJump = 1'b1;
            OP_JAL: begin
                isJump = 1'b1;
                regDst = 1'b1;
            end
            OP_ADDIU: begin
                aluOp = ALU_ADD;
                aluSrcB = 1'b1;
                immSigned = 1'b1;
                regWriteDec = 1'b1;
            end
            OP_ANDI: begin
                aluOp = ALU_AND;
                aluSrcB = 1'b1;
                regWriteDec = 1'b1;
            end
            OP_ORI: begin
                aluOp = ALU_OR;
                aluSrcB = 1'b1;
                regWriteDec = 1'b1;
            end
            OP_LUI: begin
                aluOp = ALU_LUI;
                aluSrcB = 1'b1;
                regWriteDec = 1'b1;
            end
            OP_LW: begin
                aluOp = ALU_ADD;
                aluSrcB = 1'b1;
                immSigned = 1'b1;
                memReadD = 1'b1;
                memToRegD = 1'b1;
                regWriteDec = 1'b1;
            end
            OP_SW: begin
                aluOp = ALU_ADD;
                aluSrcB = 1'b1;
                immSigned = 1'b1;
                memWriteD = 1'b1;
            end
            OP_COP0: begin
                if (instr[25:21] == COP_MF) begin
                    mfc0D = 1'b1;
                    regWriteDec = 1'b1;
                end else if (instr[25:21] == COP_MT) begin
                    mtc0D = 1'b1;
                end else if (instr[25:21] == COP_CO && instr[5:0] == COP_ERET) begin
                    eretD = 1'b1;
                end else begin
                    reservedInstr = 1'b1;
                end
            end
            default: reservedInstr = 1'b1;
        endcase
        // no side effects from an unknown encoding
        if (reservedInstr) begin
            regWriteDec = 1'b0;
            memReadD = 1'b0;
            memWriteD = 1'b0;
            mtc0D = 1'b0;
        end
    end

    assign regWriteD = (regWriteDec | linkWrite) & ~reservedInstr;

    // next instruction sits in the delay slot
    always_ff @(posedge clk) begin
        if (rst) begin
            isDelaySlot <= 1'b0;
        end else if (!stall) begin
            isDelaySlot <= isBranch | isJump | isJumpReg;
        end
    end

endmodule

// ==== src/mipsPkg.sv ====
package mipsPkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_COP0    = 6'h10,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcodeT;

    // SPECIAL function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } functT;

    // execute stage operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_LUI  = 4'd8,
        ALU_PASS = 4'd9
    } aluOpT;

    // rt field of REGIMM branches
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimmT;

endpackage

// ==== src/decode_macros.svh ====
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath and address width
`define DATA_W 32

// register index width and count
`define REG_ADDR_W 5
`define REG_COUNT 32

// coprocessor 0 register numbers
`define CP0_STATUS 5'd12
`define CP0_CAUSE 5'd13
`define CP0_EPC 5'd14

`endif
